// File: Makefile
TOP = tb_branch_predictor
BUILD = build

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-UNOPTFLAT --top-module $(TOP) \
		-Mdir $(BUILD) -o $(TOP) -f all.f

run: compile
	./$(BUILD)/$(TOP)

clean:
	rm -rf $(BUILD)

// File: all.f
+incdir+include
rtl/bp_pkg.sv
rtl/branch_target_buffer.sv
rtl/history_predictor.sv
rtl/fetch_target_chain.sv
rtl/branch_predictor.sv
sim/tb_branch_predictor.sv

// File: rtl/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // fetch group width
    localparam int lane_count = 2;

    localparam int addr_bits = 32;

    // sequential step and the byte offset bits it implies
    localparam int inst_bytes = 4;
    localparam int offset_bits = $clog2(inst_bytes);

    // target buffer geometry with the index taken from pc[5:2]
    localparam int btb_index_bits = 4;
    localparam int btb_size = 1 << btb_index_bits;
    localparam int btb_tag_bits = addr_bits - btb_index_bits - offset_bits;

    // local history table indexed by the same pc bits as the btb
    localparam int bht_index_bits = 4;
    localparam int bht_size = 1 << bht_index_bits;

    // pattern table is indexed by the full local history
    localparam int history_bits = 4;
    localparam int pht_size = 1 << history_bits;

    typedef enum logic {
        not_taken = 1'b0,
        taken     = 1'b1
    } pattern_state_t;

endpackage

`default_nettype wire

// File: rtl/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  logic                                             clock,
    input  logic                                             reset,
    input  logic [bp_pkg::addr_bits-1:0]                     pc_start,
    input  logic [bp_pkg::lane_count-1:0]                    retire_valid,
    input  logic [bp_pkg::lane_count-1:0]                    retire_taken,
    input  logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] retire_pc,
    input  logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] retire_target,
    output logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] lane_pc,
    output logic [bp_pkg::lane_count-1:0]                    predict_taken,
    output logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] predict_target
);

    logic [bp_pkg::lane_count-1:0]                         btb_hit;
    logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0]  btb_target;
    logic [bp_pkg::lane_count-1:0]                         pattern_taken;

    // target lookup for every lane address
    branch_target_buffer u_btb (
        .clock         (clock),
        .reset         (reset),
        .lane_pc       (lane_pc),
        .retire_valid  (retire_valid),
        .retire_taken  (retire_taken),
        .retire_pc     (retire_pc),
        .retire_target (retire_target),
        .btb_hit       (btb_hit),
        .btb_target    (btb_target)
    );

    // direction from local history
    history_predictor u_history (
        .clock         (clock),
        .reset         (reset),
        .lane_pc       (lane_pc),
        .retire_valid  (retire_valid),
        .retire_taken  (retire_taken),
        .retire_pc     (retire_pc),
        .pattern_taken (pattern_taken)
    );

    // lane addresses feed back into both tables one lane at a time
    fetch_target_chain u_chain (
        .pc_start       (pc_start),
        .btb_hit        (btb_hit),
        .btb_target     (btb_target),
        .pattern_taken  (pattern_taken),
        .lane_pc        (lane_pc),
        .predict_taken  (predict_taken),
        .predict_target (predict_target)
    );

endmodule

`default_nettype wire

// File: rtl/branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
    input  logic                                             clock,
    input  logic                                             reset,
    input  logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] lane_pc,
    input  logic [bp_pkg::lane_count-1:0]                    retire_valid,
    input  logic [bp_pkg::lane_count-1:0]                    retire_taken,
    input  logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] retire_pc,
    input  logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] retire_target,
    output logic [bp_pkg::lane_count-1:0]                    btb_hit,
    output logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] btb_target
);

    logic [bp_pkg::btb_size-1:0]     entry_valid;
    logic [bp_pkg::btb_tag_bits-1:0] entry_tag [bp_pkg::btb_size];
    logic [bp_pkg::addr_bits-1:0]    entry_target [bp_pkg::btb_size];

    logic [bp_pkg::lane_count-1:0][bp_pkg::btb_index_bits-1:0] lookup_index;
    logic [bp_pkg::lane_count-1:0][bp_pkg::btb_tag_bits-1:0]   lookup_tag;
    logic [bp_pkg::lane_count-1:0][bp_pkg::btb_index_bits-1:0] retire_index;
    logic [bp_pkg::lane_count-1:0][bp_pkg::btb_tag_bits-1:0]   retire_tag;
    logic [bp_pkg::lane_count-1:0]                             retire_write;

    for (genvar i = 0; i < bp_pkg::lane_count; i++) begin : g_lane
        // split addresses above the byte offset into index and tag
        assign lookup_index[i] = lane_pc[i][bp_pkg::offset_bits +: bp_pkg::btb_index_bits];
        assign lookup_tag[i]   = lane_pc[i][bp_pkg::addr_bits-1 -: bp_pkg::btb_tag_bits];
        assign retire_index[i] = retire_pc[i][bp_pkg::offset_bits +: bp_pkg::btb_index_bits];
        assign retire_tag[i]   = retire_pc[i][bp_pkg::addr_bits-1 -: bp_pkg::btb_tag_bits];

        // only taken branches allocate
        assign retire_write[i] = retire_valid[i] && retire_taken[i];

        assign btb_hit[i]    = entry_valid[lookup_index[i]]
                               && (entry_tag[lookup_index[i]] == lookup_tag[i]);
        assign btb_target[i] = entry_target[lookup_index[i]];
    end

    // lanes are walked in order so the higher lane wins a shared index
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            for (int i = 0; i < bp_pkg::lane_count; i++) begin
                if (retire_write[i]) begin
                    entry_valid[retire_index[i]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < bp_pkg::lane_count; i++) begin
            if (retire_write[i]) begin
                entry_tag[retire_index[i]]    <= retire_tag[i];
                entry_target[retire_index[i]] <= retire_target[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_target_chain.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_target_chain (
    input  logic [bp_pkg::addr_bits-1:0]                     pc_start,
    input  logic [bp_pkg::lane_count-1:0]                    btb_hit,
    input  logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] btb_target,
    input  logic [bp_pkg::lane_count-1:0]                    pattern_taken,
    output logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] lane_pc,
    output logic [bp_pkg::lane_count-1:0]                    predict_taken,
    output logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] predict_target
);

    // fall-through address of each lane
    logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] sequential_pc;

    assign lane_pc[0] = pc_start;

    for (genvar i = 0; i < bp_pkg::lane_count; i++) begin : g_lane
        assign sequential_pc[i] = lane_pc[i] + bp_pkg::addr_bits'(bp_pkg::inst_bytes);

        // taken needs a taken pattern and a target to go to
        assign predict_taken[i]  = pattern_taken[i] && btb_hit[i];
        assign predict_target[i] = predict_taken[i] ? btb_target[i] : sequential_pc[i];

        // next lane starts wherever this lane goes
        if (i < bp_pkg::lane_count - 1) begin : g_link
            assign lane_pc[i+1] = predict_target[i];
        end
    end

endmodule

`default_nettype wire

// File: rtl/history_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module history_predictor (
    input  logic                                             clock,
    input  logic                                             reset,
    input  logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] lane_pc,
    input  logic [bp_pkg::lane_count-1:0]                    retire_valid,
    input  logic [bp_pkg::lane_count-1:0]                    retire_taken,
    input  logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] retire_pc,
    output logic [bp_pkg::lane_count-1:0]                    pattern_taken
);

    // per-branch local histories
    logic [bp_pkg::history_bits-1:0] history_table [bp_pkg::bht_size];
    logic [bp_pkg::history_bits-1:0] next_history_table [bp_pkg::bht_size];

    // one-bit direction state per history pattern
    bp_pkg::pattern_state_t pattern_table [bp_pkg::pht_size];
    bp_pkg::pattern_state_t next_pattern_table [bp_pkg::pht_size];

    logic [bp_pkg::lane_count-1:0][bp_pkg::bht_index_bits-1:0] lookup_index;
    logic [bp_pkg::lane_count-1:0][bp_pkg::history_bits-1:0]   lookup_history;
    logic [bp_pkg::lane_count-1:0][bp_pkg::bht_index_bits-1:0] retire_index;

    for (genvar i = 0; i < bp_pkg::lane_count; i++) begin : g_lane
        assign lookup_index[i] = lane_pc[i][bp_pkg::offset_bits +: bp_pkg::bht_index_bits];
        assign retire_index[i] = retire_pc[i][bp_pkg::offset_bits +: bp_pkg::bht_index_bits];

        // two-level read of the history and then the pattern it selects
        assign lookup_history[i] = history_table[lookup_index[i]];
        assign pattern_taken[i]  = (pattern_table[lookup_history[i]] == bp_pkg::taken);
    end

    always_comb begin
        next_history_table = history_table;
        next_pattern_table = pattern_table;

        for (int i = 0; i < bp_pkg::lane_count; i++) begin
            if (retire_valid[i]) begin
                // shift builds on earlier lanes when the index is shared
                next_history_table[retire_index[i]] = {
                    next_history_table[retire_index[i]][bp_pkg::history_bits-2:0],
                    retire_taken[i]
                };

                // trained entry comes from the history before this edge
                next_pattern_table[history_table[retire_index[i]]] =
                    retire_taken[i] ? bp_pkg::taken : bp_pkg::not_taken;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            history_table <= '{default: '0};
            pattern_table <= '{default: bp_pkg::not_taken};
        end else begin
            history_table <= next_history_table;
            pattern_table <= next_pattern_table;
        end
    end

endmodule

`default_nettype wire

// File: include/bp_ref_model.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// mirror of the btb entries
logic                              model_btb_valid  [bp_pkg::btb_size];
logic [bp_pkg::btb_tag_bits-1:0]   model_btb_tag    [bp_pkg::btb_size];
logic [bp_pkg::addr_bits-1:0]      model_btb_target [bp_pkg::btb_size];

// mirror of the local histories and pattern states
logic [bp_pkg::history_bits-1:0]   model_history    [bp_pkg::bht_size];
bp_pkg::pattern_state_t            model_pattern    [bp_pkg::pht_size];

// expected outputs for the current pc_start
logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] expect_lane_pc;
logic [bp_pkg::lane_count-1:0]                        expect_taken;
logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] expect_target;

function automatic void clear_model();
    model_btb_valid = '{default: 1'b0};
    model_history   = '{default: '0};
    model_pattern   = '{default: bp_pkg::not_taken};
endfunction

function automatic void update_model(
    input logic [bp_pkg::lane_count-1:0]                        valid,
    input logic [bp_pkg::lane_count-1:0]                        taken,
    input logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] pc,
    input logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] target
);
    logic [bp_pkg::history_bits-1:0] old_history [bp_pkg::bht_size];
    int unsigned btb_idx;
    int unsigned bht_idx;
    old_history = model_history;
    for (int i = 0; i < bp_pkg::lane_count; i++) begin
        if (valid[i]) begin
            btb_idx = pc[i][bp_pkg::offset_bits +: bp_pkg::btb_index_bits];
            bht_idx = pc[i][bp_pkg::offset_bits +: bp_pkg::bht_index_bits];
            if (taken[i]) begin
                model_btb_valid[btb_idx]  = 1'b1;
                model_btb_tag[btb_idx]    = pc[i][bp_pkg::addr_bits-1 -: bp_pkg::btb_tag_bits];
                model_btb_target[btb_idx] = target[i];
            end
            // pattern uses the history from before this edge
            model_pattern[old_history[bht_idx]] = taken[i] ? bp_pkg::taken : bp_pkg::not_taken;
            model_history[bht_idx] = {model_history[bht_idx][bp_pkg::history_bits-2:0], taken[i]};
        end
    end
endfunction

function automatic void compute_expected(input logic [bp_pkg::addr_bits-1:0] pc_start);
    logic [bp_pkg::addr_bits-1:0] pc;
    int unsigned btb_idx;
    logic hit;
    pc = pc_start;
    for (int i = 0; i < bp_pkg::lane_count; i++) begin
        btb_idx = pc[bp_pkg::offset_bits +: bp_pkg::btb_index_bits];
        hit = model_btb_valid[btb_idx]
              && (model_btb_tag[btb_idx] == pc[bp_pkg::addr_bits-1 -: bp_pkg::btb_tag_bits]);
        expect_lane_pc[i] = pc;
        expect_taken[i] = hit && (model_pattern[model_history[
            pc[bp_pkg::offset_bits +: bp_pkg::bht_index_bits]]] == bp_pkg::taken);
        expect_target[i] = expect_taken[i] ? model_btb_target[btb_idx]
                                           : pc + bp_pkg::addr_bits'(bp_pkg::inst_bytes);
        pc = expect_target[i];
    end
endfunction

`endif

// File: sim/tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

    localparam int clock_period = 20;
    localparam int reset_cycles = 8;
    localparam int learn_limit = 20;
    localparam int random_cycles = 400;
    localparam int run_limit = 2000;
    localparam logic [bp_pkg::addr_bits-1:0] inst_step = bp_pkg::addr_bits'(bp_pkg::inst_bytes);

    // trained loop branch and the branch at its target
    localparam logic [bp_pkg::addr_bits-1:0] branch_pc = 32'h0000_1018;
    localparam logic [bp_pkg::addr_bits-1:0] branch_target = 32'h0000_2040;
    localparam logic [bp_pkg::addr_bits-1:0] chain_target = 32'h0000_3000;

    logic                                                 clock = 1'b0;
    logic                                                 reset;
    logic [bp_pkg::addr_bits-1:0]                         pc_start;
    logic [bp_pkg::lane_count-1:0]                        retire_valid;
    logic [bp_pkg::lane_count-1:0]                        retire_taken;
    logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] retire_pc;
    logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] retire_target;
    logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] lane_pc;
    logic [bp_pkg::lane_count-1:0]                        predict_taken;
    logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] predict_target;

    integer seed;

    `include "bp_ref_model.svh"

    branch_predictor DUT (
        .clock          (clock),
        .reset          (reset),
        .pc_start       (pc_start),
        .retire_valid   (retire_valid),
        .retire_taken   (retire_taken),
        .retire_pc      (retire_pc),
        .retire_target  (retire_target),
        .lane_pc        (lane_pc),
        .predict_taken  (predict_taken),
        .predict_target (predict_target)
    );

    initial begin
        forever #(clock_period / 2) clock = ~clock;
    end

    task automatic report_mismatch(input string what);
        $display("FAIL at %0t ns: %s", $time, what);
        $display("test failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    // checked every cycle just before the edge
    lane_pc_match: assert property (@(posedge clock) disable iff (reset)
        lane_pc == expect_lane_pc)
        else report_mismatch($sformatf("lane_pc %h, expected %h",
                                       $sampled(lane_pc), $sampled(expect_lane_pc)));

    taken_match: assert property (@(posedge clock) disable iff (reset)
        predict_taken == expect_taken)
        else report_mismatch($sformatf("predict_taken %b, expected %b",
                                       $sampled(predict_taken), $sampled(expect_taken)));

    target_match: assert property (@(posedge clock) disable iff (reset)
        predict_target == expect_target)
        else report_mismatch($sformatf("predict_target %h, expected %h",
                                       $sampled(predict_target), $sampled(expect_target)));

    initial begin
        for (int n = 0; n < run_limit; n++) begin
            @(posedge clock);
        end
        abort_run("watchdog: simulation ran past its cycle limit");
    end

    // small address window so tags and indexes collide often
    function automatic logic [bp_pkg::addr_bits-1:0] random_pc();
        logic [bp_pkg::addr_bits-1:0] r;
        r = $random(seed);
        return 32'h0000_1000 | (r & 32'h0000_00fc);
    endfunction

    // the model follows whatever the DUT saw at the last edge
    task automatic next_cycle();
        @(negedge clock);
        if (reset) begin
            clear_model();
        end else begin
            update_model(retire_valid, retire_taken, retire_pc, retire_target);
        end
    endtask

    task automatic drive_cycle(
        input logic [bp_pkg::addr_bits-1:0]                         pc,
        input logic [bp_pkg::lane_count-1:0]                        valid,
        input logic [bp_pkg::lane_count-1:0]                        taken,
        input logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] rpc,
        input logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] rtarget
    );
        next_cycle();
        pc_start = pc;
        retire_valid = valid;
        retire_taken = taken;
        retire_pc = rpc;
        retire_target = rtarget;
        compute_expected(pc);
    endtask

    // give the combinational outputs time to settle before reading
    task automatic settle();
        #(clock_period / 4);
    endtask

    task automatic apply_reset();
        next_cycle();
        reset = 1'b1;
        drive_cycle(pc_start, '0, '0, '0, '0);
        for (int n = 1; n < reset_cycles; n++) begin
            next_cycle();
        end
        reset = 1'b0;
        compute_expected(pc_start);
    endtask

    task automatic check_reset_state();
        logic [bp_pkg::addr_bits-1:0] pc;
        for (int n = 0; n < 8; n++) begin
            pc = random_pc();
            drive_cycle(pc, '0, '0, '0, '0);
            settle();
            assert (predict_taken == '0
                    && lane_pc[1] == pc + inst_step
                    && predict_target[0] == pc + inst_step
                    && predict_target[1] == pc + inst_step + inst_step)
                else report_mismatch($sformatf("reset state wrong for pc %h", pc));
        end
    endtask

    // retire one branch as taken on a lane until a fetch there predicts taken
    task automatic learn_branch(
        input logic [bp_pkg::addr_bits-1:0] pc,
        input logic [bp_pkg::addr_bits-1:0] target,
        input int                           lane
    );
        logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] rpc;
        logic [bp_pkg::lane_count-1:0][bp_pkg::addr_bits-1:0] rtarget;
        logic [bp_pkg::lane_count-1:0]                        strobe;
        logic                                                 learned;
        rpc = '0;
        rtarget = '0;
        rpc[lane] = pc;
        rtarget[lane] = target;
        strobe = 2'b01 << lane;
        learned = 1'b0;
        for (int n = 0; n < learn_limit && !learned; n++) begin
            drive_cycle(pc, strobe, strobe, rpc, rtarget);
            settle();
            learned = predict_taken[0];
        end
        if (!learned) begin
            abort_run($sformatf("branch at %h was never predicted taken", pc));
        end
        assert (predict_target[0] == target)
            else report_mismatch($sformatf("learned target %h, expected %h",
                                           predict_target[0], target));
    endtask

    task automatic random_stream();
        logic [bp_pkg::lane_count-1:0]                        valid;
        logic [bp_pkg::lane_count-1:0]                        taken;
        logic [bp_pkg::addr_bits-1:0]                         pc0;
        logic [bp_pkg::addr_bits-1:0]                         pc1;
        logic [bp_pkg::addr_bits-1:0]                         fetch;
        logic [bp_pkg::addr_bits-1:0]                         last_retired;
        last_retired = branch_pc;
        for (int n = 0; n < random_cycles; n++) begin
            valid = 2'($random(seed));
            taken = 2'($random(seed));
            pc0 = random_pc();
            pc1 = random_pc();
            // force a shared index now and then
            if (($random(seed) & 3) == 0) begin
                pc1 = (pc1 & ~32'h0000_003c) | (pc0 & 32'h0000_003c);
            end
            if (($random(seed) & 1) == 0) begin
                fetch = last_retired;
            end else begin
                fetch = random_pc();
            end
            drive_cycle(fetch, valid, taken, {pc1, pc0}, {random_pc(), random_pc()});
            if (valid[0]) begin
                last_retired = pc0;
            end
        end
    endtask

    initial begin
        seed = 49758;
        reset = 1'b1;
        pc_start = '0;
        retire_valid = '0;
        retire_taken = '0;
        retire_pc = '0;
        retire_target = '0;
        clear_model();
        compute_expected(pc_start);

        for (int n = 0; n < reset_cycles; n++) begin
            next_cycle();
        end
        reset = 1'b0;
        compute_expected(pc_start);

        check_reset_state();

        learn_branch(branch_pc, branch_target, 0);

        // same index and history, different tag
        drive_cycle(branch_pc ^ 32'h0000_0100, '0, '0, '0, '0);
        settle();
        assert (predict_taken[0] == 1'b0
                && predict_target[0] == (branch_pc ^ 32'h0000_0100) + inst_step)
            else report_mismatch("tag miss still predicted taken");

        // lane 1 fetches the target of lane 0
        learn_branch(branch_target, chain_target, 1);
        drive_cycle(branch_pc, '0, '0, '0, '0);
        settle();
        assert (lane_pc[1] == branch_target
                && predict_taken == 2'b11
                && predict_target[1] == chain_target)
            else report_mismatch($sformatf("chain lane_pc %h target %h taken %b",
                                           lane_pc[1], predict_target[1], predict_taken));

        random_stream();

        apply_reset();
        check_reset_state();

        next_cycle();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
